// ==== Makefile ====
VERILATOR ?= verilator
TOP       := ringSystemTb
FILELIST  := all.f
FLAGS     := --binary -j 0 --timescale 1ns/1ps --top-module $(TOP)
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
+incdir+common
common/ringPkg.sv
verilog/sharedMemory.sv
verilog/memArbiter.sv
ringBuffer/memClient.sv
ringBuffer/ringBuffer.sv
verilog/ringSystem.sv
test/ringChecker.sv
test/ringSystemTb.sv

// ==== common/ringPkg.sv ====
`default_nettype none

`include "ring_defs.svh"

package ringPkg;

	// ====================
	// Memory side
	// ====================
	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} memOp_e;

	typedef struct packed {
		memOp_e op;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] wdata; // Ignored on reads
	} memReq_t;

	// ====================
	// Ring side
	// ====================
	typedef enum logic [1:0] {
		RING_OK,
		RING_FULL,
		RING_EMPTY
	} ringStatus_e;

	typedef struct packed {
		logic open;
		logic commit;
		logic rollback;
	} ringCtrl_t;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] data;
		ringStatus_e status;
	} popRsp_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		READ,
		DONE
	} ringState_e;

endpackage

`default_nettype wire

// ==== common/ring_defs.svh ====
`ifndef RING_DEFS_SVH
`define RING_DEFS_SVH

// ====================
// Memory geometry
// ====================
`define DATA_WIDTH 16
`define ADDR_WIDTH 8
`define MEM_DEPTH 256

// ====================
// Ring layout
// ====================
`define NUM_RINGS 2

`define RING0_START 8'h00 // Three words
`define RING0_END 8'h02
`define RING1_START 8'h10 // Four words
`define RING1_END 8'h13

`endif

// ==== ringBuffer/memClient.sv ====
`default_nettype none

`include "ring_defs.svh"

module memClient (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   memStart,
	input  ringPkg::memReq_t       access,
	input  logic                   gnt,
	input  logic [`DATA_WIDTH-1:0] rdata,
	output logic                   req,
	output ringPkg::memReq_t       clientReq,
	output logic                   memDone,
	output logic [`DATA_WIDTH-1:0] memRdata
);
	import ringPkg::*;

	logic rdWait; // Set for the cycle after a granted read

	// ====================
	// Request and done
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			req <= 1'b0;
			rdWait <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			rdWait <= 1'b0;
			if (memStart) begin
				req <= 1'b1;
			end else if (req && gnt) begin
				req <= 1'b0;
				if (clientReq.op == MEM_WRITE) begin
					memDone <= 1'b1; // Write is complete at the granted edge
				end else begin
					rdWait <= 1'b1;
				end
			end
			if (rdWait) begin
				memDone <= 1'b1;
			end
		end
	end

	// Latched access and captured read word
	always_ff @(posedge clk) begin
		if (memStart) begin
			clientReq <= access;
		end
		if (rdWait) begin
			memRdata <= rdata;
		end
	end

endmodule

`default_nettype wire

// ==== ringBuffer/ringBuffer.sv ====
`default_nettype none

`include "ring_defs.svh"

module ringBuffer #(
	parameter logic [`ADDR_WIDTH-1:0] startAddr = `RING0_START,
	parameter logic [`ADDR_WIDTH-1:0] endAddr = `RING0_END
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   pushValid,
	input  logic [`DATA_WIDTH-1:0] pushData,
	input  logic                   popValid,
	input  ringPkg::ringCtrl_t     ctrl,
	input  logic                   memDone,
	input  logic [`DATA_WIDTH-1:0] memRdata,
	output logic                   pushDone,
	output ringPkg::ringStatus_e   pushStatus,
	output logic                   popDone,
	output ringPkg::popRsp_t       popRsp,
	output logic                   memStart,
	output ringPkg::memReq_t       access
);
	import ringPkg::*;

	localparam logic [`ADDR_WIDTH:0] capacity = {1'b0, endAddr} - {1'b0, startAddr} + 1'b1;

	ringState_e             state;
	logic [`ADDR_WIDTH-1:0] rdPtr;
	logic [`ADDR_WIDTH-1:0] wrPtr;
	logic [`ADDR_WIDTH-1:0] snapPtr; // Write pointer at open
	logic [`ADDR_WIDTH:0]   commitCnt; // Words visible to pop
	logic [`ADDR_WIDTH:0]   pendCnt; // Words pushed since open
	logic                   txnOpen;
	logic                   pushPend;
	logic                   popPend;
	logic [`DATA_WIDTH-1:0] pushDataQ;

	logic                   ctrlAny;
	logic                   isFull;
	logic                   isEmpty;
	logic                   startPush;
	logic                   startPop;
	logic [`DATA_WIDTH-1:0] curData;

	function automatic logic [`ADDR_WIDTH-1:0] nextPtr(input logic [`ADDR_WIDTH-1:0] ptr);
		return (ptr == endAddr) ? startAddr : ptr + 1'b1;
	endfunction

	// ====================
	// Request decode
	// ====================
	always_comb begin
		ctrlAny = ctrl.open | ctrl.commit | ctrl.rollback;
		isFull = (commitCnt + pendCnt) == capacity;
		isEmpty = commitCnt == '0;
		startPush = state == IDLE && !ctrlAny && (pushValid || pushPend);
		startPop = state == IDLE && !ctrlAny && !(pushValid || pushPend) && (popValid || popPend);
		curData = pushValid ? pushData : pushDataQ;
	end

	// ====================
	// FSM and pointers
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
			rdPtr <= startAddr;
			wrPtr <= startAddr;
			snapPtr <= startAddr;
			commitCnt <= '0;
			pendCnt <= '0;
			txnOpen <= 1'b0;
			pushPend <= 1'b0;
			popPend <= 1'b0;
			pushDone <= 1'b0;
			popDone <= 1'b0;
			memStart <= 1'b0;
		end else begin
			pushDone <= 1'b0;
			popDone <= 1'b0;
			memStart <= 1'b0;
			if (pushValid) pushPend <= 1'b1; // Served later if the ring is busy
			if (popValid) popPend <= 1'b1;
			case (state)
				IDLE: begin
					if (ctrlAny) begin
						if (ctrl.open) begin
							snapPtr <= wrPtr;
							txnOpen <= 1'b1;
						end
						if (ctrl.commit) begin
							commitCnt <= commitCnt + pendCnt;
							pendCnt <= '0;
							txnOpen <= 1'b0;
						end
						if (ctrl.rollback) begin
							wrPtr <= snapPtr; // Drop every push since open
							pendCnt <= '0;
							txnOpen <= 1'b0;
						end
					end else if (startPush) begin
						pushPend <= 1'b0;
						if (isFull) begin
							pushDone <= 1'b1;
							state <= DONE;
						end else begin
							memStart <= 1'b1;
							state <= WRITE;
						end
					end else if (startPop) begin
						popPend <= 1'b0;
						if (isEmpty) begin
							popDone <= 1'b1;
							state <= DONE;
						end else begin
							memStart <= 1'b1;
							state <= READ;
						end
					end
				end
				WRITE: begin
					if (memDone) begin
						wrPtr <= nextPtr(wrPtr);
						if (txnOpen) pendCnt <= pendCnt + 1'b1;
						else commitCnt <= commitCnt + 1'b1;
						pushDone <= 1'b1;
						state <= DONE;
					end
				end
				READ: begin
					if (memDone) begin
						rdPtr <= nextPtr(rdPtr);
						commitCnt <= commitCnt - 1'b1;
						popDone <= 1'b1;
						state <= DONE;
					end
				end
				default: begin
					state <= IDLE; // Done pulse is out this cycle
				end
			endcase
		end
	end

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk) begin
		if (pushValid) pushDataQ <= pushData;
		if (startPush) begin
			pushStatus <= isFull ? RING_FULL : RING_OK;
			access <= '{op: MEM_WRITE, addr: wrPtr, wdata: curData};
		end
		if (startPop) begin
			popRsp <= '{data: '0, status: RING_EMPTY};
			access <= '{op: MEM_READ, addr: rdPtr, wdata: '0};
		end
		if (state == READ && memDone) begin
			popRsp <= '{data: memRdata, status: RING_OK};
		end
	end

endmodule

`default_nettype wire

// ==== test/ringChecker.sv ====
`default_nettype none

`include "ring_defs.svh"

module ringChecker (
	input  logic                   clk,
	input  logic [`NUM_RINGS-1:0]  pushDone,
	input  ringPkg::ringStatus_e   pushStatus [`NUM_RINGS],
	input  logic [`NUM_RINGS-1:0]  popDone,
	input  ringPkg::popRsp_t       popRsp [`NUM_RINGS],
	input  ringPkg::ringCtrl_t     ctrl [`NUM_RINGS],
	input  int                     expIdx [`NUM_RINGS],
	input  logic [`NUM_RINGS-1:0]  expPop,
	input  ringPkg::ringStatus_e   expStatus [`NUM_RINGS],
	input  logic [`DATA_WIDTH-1:0] expData [`NUM_RINGS],
	output int                     passCnt,
	output int                     failCnt
);
	timeunit 1ns;
	timeprecision 1ps;
	import ringPkg::*;

	initial begin
		passCnt = 0;
		failCnt = 0;
	end

	task automatic reportCtrl(input int r);
		string what;
		what = ctrl[r].open ? "open" : (ctrl[r].commit ? "commit" : "rollback");
		$display("Entry %0d ring %0d: %s applied", expIdx[r], r, what);
	endtask

	task automatic checkPush(input int r);
		if (expPop[r]) begin
			$display("Entry %0d ring %0d: push done arrived while a pop was expected",
				expIdx[r], r);
			failCnt++;
		end else if (pushStatus[r] !== expStatus[r]) begin
			$display("** Error at %0t ns: entry %0d ring %0d push status %s, expected %s",
				$time, expIdx[r], r, pushStatus[r].name(), expStatus[r].name());
			failCnt++;
		end else begin
			$display("Entry %0d ring %0d: push %s", expIdx[r], r, pushStatus[r].name());
			passCnt++;
		end
	endtask

	task automatic checkPop(input int r);
		if (!expPop[r]) begin
			$display("Entry %0d ring %0d: pop done arrived while a push was expected",
				expIdx[r], r);
			failCnt++;
		end else if (popRsp[r].status !== expStatus[r] || popRsp[r].data !== expData[r]) begin
			$display("** Error at %0t ns: entry %0d ring %0d pop %s %h, expected %s %h",
				$time, expIdx[r], r, popRsp[r].status.name(), popRsp[r].data,
				expStatus[r].name(), expData[r]);
			failCnt++;
		end else begin
			$display("Entry %0d ring %0d: pop %s %h", expIdx[r], r,
				popRsp[r].status.name(), popRsp[r].data);
			passCnt++;
		end
	endtask

	// Done pulses and ctrl are stable at the falling edge
	always @(negedge clk) begin
		for (int r = 0; r < `NUM_RINGS; r++) begin
			if (ctrl[r] != '0) reportCtrl(r);
			if (pushDone[r]) checkPush(r);
			if (popDone[r]) checkPop(r);
		end
	end

endmodule

`default_nettype wire

// ==== test/ringSystemTb.sv ====
`default_nettype none

`include "ring_defs.svh"

module ringSystemTb;
	timeunit 1ns;
	timeprecision 1ps;
	import ringPkg::*;

	typedef enum logic [2:0] {
		OP_PUSH,
		OP_POP,
		OP_OPEN,
		OP_COMMIT,
		OP_ROLLBACK
	} testOp_e;

	typedef struct packed {
		logic                   ring;
		logic                   pair; // Issued in the same cycle as the next entry
		testOp_e                op;
		logic [`DATA_WIDTH-1:0] data;
		ringStatus_e            status;
		logic [`DATA_WIDTH-1:0] popData;
	} entry_t;

	localparam int NUM_ENTRIES = 37;
	localparam int TIMEOUT = NUM_ENTRIES * 20 + 50;

	// ====================
	// Stimulus table
	// ====================
	localparam entry_t tests [NUM_ENTRIES] = '{
		'{1'b0, 1'b0, OP_PUSH, 16'h1111, RING_OK, 16'h0000}, // Push order
		'{1'b0, 1'b0, OP_PUSH, 16'h2222, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'h1111},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'h2222},
		'{1'b0, 1'b0, OP_PUSH, 16'hA001, RING_OK, 16'h0000}, // Fill ring 0
		'{1'b0, 1'b0, OP_PUSH, 16'hA002, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'hA003, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'hA004, RING_FULL, 16'h0000},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hA001},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hA002},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hA003},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_EMPTY, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'hB001, RING_OK, 16'h0000}, // Wraps past 0x02
		'{1'b0, 1'b0, OP_PUSH, 16'hB002, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hB001},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hB002},
		'{1'b0, 1'b1, OP_PUSH, 16'hC0C0, RING_OK, 16'h0000}, // Both rings at once
		'{1'b1, 1'b0, OP_PUSH, 16'hD1D1, RING_OK, 16'h0000},
		'{1'b0, 1'b1, OP_POP, 16'h0000, RING_OK, 16'hC0C0},
		'{1'b1, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hD1D1},
		'{1'b1, 1'b0, OP_OPEN, 16'h0000, RING_OK, 16'h0000}, // Commit
		'{1'b1, 1'b0, OP_PUSH, 16'hE001, RING_OK, 16'h0000},
		'{1'b1, 1'b0, OP_POP, 16'h0000, RING_EMPTY, 16'h0000},
		'{1'b1, 1'b0, OP_COMMIT, 16'h0000, RING_OK, 16'h0000},
		'{1'b1, 1'b0, OP_POP, 16'h0000, RING_OK, 16'hE001},
		'{1'b0, 1'b0, OP_OPEN, 16'h0000, RING_OK, 16'h0000}, // Rollback
		'{1'b0, 1'b0, OP_PUSH, 16'hF001, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'hF002, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_ROLLBACK, 16'h0000, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_EMPTY, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'h7001, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'h7002, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'h7003, RING_OK, 16'h0000},
		'{1'b0, 1'b0, OP_PUSH, 16'h7004, RING_FULL, 16'h0000},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'h7001},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'h7002},
		'{1'b0, 1'b0, OP_POP, 16'h0000, RING_OK, 16'h7003}
	};

	logic                   clk;
	logic                   rstN;
	logic [`NUM_RINGS-1:0]  pushValid;
	logic [`DATA_WIDTH-1:0] pushData [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  popValid;
	ringCtrl_t              ctrl [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  pushDone;
	ringStatus_e            pushStatus [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  popDone;
	popRsp_t                popRsp [`NUM_RINGS];
	int                     expIdx [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  expPop;
	ringStatus_e            expStatus [`NUM_RINGS];
	logic [`DATA_WIDTH-1:0] expData [`NUM_RINGS];
	int                     passCnt;
	int                     failCnt;
	int                     cycles = 0;

	ringSystem i_dut (
		.clk(clk), .rstN(rstN),
		.pushValid(pushValid), .pushData(pushData), .popValid(popValid), .ctrl(ctrl),
		.pushDone(pushDone), .pushStatus(pushStatus), .popDone(popDone), .popRsp(popRsp)
	);

	ringChecker resultCheck (
		.clk(clk), .pushDone(pushDone), .pushStatus(pushStatus), .popDone(popDone),
		.popRsp(popRsp), .ctrl(ctrl), .expIdx(expIdx), .expPop(expPop),
		.expStatus(expStatus), .expData(expData), .passCnt(passCnt), .failCnt(failCnt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles while waiting for a done pulse", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ====================
	// Drive helpers
	// ====================
	task automatic clearInputs();
		pushValid = '0;
		popValid = '0;
		for (int r = 0; r < `NUM_RINGS; r++) begin
			ctrl[r] = '0;
		end
	endtask

	task automatic applyEntry(input int idx);
		entry_t e;
		e = tests[idx];
		expIdx[e.ring] = idx;
		expPop[e.ring] = (e.op == OP_POP);
		expStatus[e.ring] = e.status;
		expData[e.ring] = e.popData;
		case (e.op)
			OP_PUSH: begin
				pushValid[e.ring] = 1'b1;
				pushData[e.ring] = e.data;
			end
			OP_POP: popValid[e.ring] = 1'b1;
			OP_OPEN: ctrl[e.ring].open = 1'b1;
			OP_COMMIT: ctrl[e.ring].commit = 1'b1;
			default: ctrl[e.ring].rollback = 1'b1;
		endcase
	endtask

	task automatic waitDone(input logic [`NUM_RINGS-1:0] wanted);
		logic [`NUM_RINGS-1:0] seen;
		seen = '0;
		while ((seen & wanted) != wanted) begin
			@(negedge clk);
			seen = seen | (pushDone & ~expPop) | (popDone & expPop);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int i;
		int expectedChecks;
		logic [`NUM_RINGS-1:0] wanted;
		rstN = 1'b0;
		clearInputs();
		expPop = '0;
		for (int r = 0; r < `NUM_RINGS; r++) begin
			pushData[r] = '0;
			expIdx[r] = 0;
			expStatus[r] = RING_OK;
			expData[r] = '0;
		end
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		i = 0;
		expectedChecks = 0;
		while (i < NUM_ENTRIES) begin
			@(posedge clk);
			#1;
			wanted = '0;
			do begin
				applyEntry(i);
				if (tests[i].op inside {OP_PUSH, OP_POP}) begin
					wanted[tests[i].ring] = 1'b1;
					expectedChecks++;
				end
				i++;
			end while (tests[i-1].pair && i < NUM_ENTRIES);
			@(posedge clk);
			#1;
			clearInputs(); // Requests are one-cycle pulses
			waitDone(wanted);
		end
		repeat (2) @(posedge clk);
		$display("Checks passed: %0d, failed: %0d", passCnt, failCnt);
		if (failCnt == 0 && passCnt == expectedChecks) begin
			$display("Test completed successfully");
		end else begin
			if (passCnt + failCnt != expectedChecks)
				$display("Only %0d of %0d checks were seen", passCnt + failCnt, expectedChecks);
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/memArbiter.sv ====
`default_nettype none

`include "ring_defs.svh"

module memArbiter (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [`NUM_RINGS-1:0] req,
	input  ringPkg::memReq_t      clientReq [`NUM_RINGS],
	output logic [`NUM_RINGS-1:0] gnt,
	output logic                  memEn,
	output ringPkg::memReq_t      memReq
);
	localparam int idxW = (`NUM_RINGS > 1) ? $clog2(`NUM_RINGS) : 1;

	logic [idxW-1:0] lastWin; // Client that won the previous access
	logic [idxW-1:0] winner;
	logic            found;

	// ====================
	// Round-robin pick
	// ====================
	always_comb begin
		int cand;
		found = 1'b0;
		winner = lastWin;
		gnt = '0;
		// Search starts just past the last winner
		for (int i = 1; i <= `NUM_RINGS; i++) begin
			cand = (int'(lastWin) + i) % `NUM_RINGS;
			if (!found && req[cand]) begin
				found = 1'b1;
				winner = idxW'(cand);
			end
		end
		if (found) begin
			gnt[winner] = 1'b1;
		end
	end

	assign memEn = found;
	assign memReq = clientReq[winner]; // Don't care while memEn is low

	always_ff @(posedge clk) begin
		if (!rstN) begin
			lastWin <= idxW'(`NUM_RINGS - 1); // Client 0 goes first after reset
		end else if (found) begin
			lastWin <= winner;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ringSystem.sv ====
`default_nettype none

`include "ring_defs.svh"

module ringSystem (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [`NUM_RINGS-1:0]  pushValid,
	input  logic [`DATA_WIDTH-1:0] pushData [`NUM_RINGS],
	input  logic [`NUM_RINGS-1:0]  popValid,
	input  ringPkg::ringCtrl_t     ctrl [`NUM_RINGS],
	output logic [`NUM_RINGS-1:0]  pushDone,
	output ringPkg::ringStatus_e   pushStatus [`NUM_RINGS],
	output logic [`NUM_RINGS-1:0]  popDone,
	output ringPkg::popRsp_t       popRsp [`NUM_RINGS]
);
	import ringPkg::*;

	logic [`NUM_RINGS-1:0]  memStart;
	memReq_t                access [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  memDone;
	logic [`DATA_WIDTH-1:0] memRdata [`NUM_RINGS];
	logic [`NUM_RINGS-1:0]  req;
	logic [`NUM_RINGS-1:0]  gnt;
	memReq_t                clientReq [`NUM_RINGS];
	logic                   memEn;
	memReq_t                memReq;
	logic [`DATA_WIDTH-1:0] rdata;

	// ====================
	// Rings
	// ====================
	ringBuffer #(.startAddr(`RING0_START), .endAddr(`RING0_END)) ring0 (
		.clk(clk), .rstN(rstN),
		.pushValid(pushValid[0]), .pushData(pushData[0]), .popValid(popValid[0]),
		.ctrl(ctrl[0]), .memDone(memDone[0]), .memRdata(memRdata[0]),
		.pushDone(pushDone[0]), .pushStatus(pushStatus[0]),
		.popDone(popDone[0]), .popRsp(popRsp[0]),
		.memStart(memStart[0]), .access(access[0])
	);

	ringBuffer #(.startAddr(`RING1_START), .endAddr(`RING1_END)) ring1 (
		.clk(clk), .rstN(rstN),
		.pushValid(pushValid[1]), .pushData(pushData[1]), .popValid(popValid[1]),
		.ctrl(ctrl[1]), .memDone(memDone[1]), .memRdata(memRdata[1]),
		.pushDone(pushDone[1]), .pushStatus(pushStatus[1]),
		.popDone(popDone[1]), .popRsp(popRsp[1]),
		.memStart(memStart[1]), .access(access[1])
	);

	// ====================
	// Memory path
	// ====================
	for (genvar i = 0; i < `NUM_RINGS; i++) begin : genClient
		memClient client (
			.clk(clk), .rstN(rstN),
			.memStart(memStart[i]), .access(access[i]), .gnt(gnt[i]), .rdata(rdata),
			.req(req[i]), .clientReq(clientReq[i]),
			.memDone(memDone[i]), .memRdata(memRdata[i])
		);
	end

	memArbiter arbiter (
		.clk(clk), .rstN(rstN), .req(req), .clientReq(clientReq),
		.gnt(gnt), .memEn(memEn), .memReq(memReq)
	);

	sharedMemory memory (
		.clk(clk), .rstN(rstN), .en(memEn), .req(memReq), .rdata(rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/sharedMemory.sv ====
`default_nettype none

`include "ring_defs.svh"

module sharedMemory (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   en,
	input  ringPkg::memReq_t       req,
	output logic [`DATA_WIDTH-1:0] rdata
);
	import ringPkg::*;

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (en && req.op == MEM_WRITE) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// Read word is registered and valid one cycle after the access
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdata <= '0;
		end else if (en && req.op == MEM_READ) begin
			rdata <= mem[req.addr];
		end
	end

endmodule

`default_nettype wire
